// ==== sources.f ====
+incdir+verif
logic/alu_pkg.sv
logic/alu_arith.sv
logic/alu_shift.sv
logic/alu_result_stage.sv
logic/alu_top.sv
verif/tb_alu_top.sv

// ==== Bender.yml ====
package:
  name: alu

sources:
  - files:
      - logic/alu_pkg.sv
      - logic/alu_arith.sv
      - logic/alu_shift.sv
      - logic/alu_result_stage.sv
      - logic/alu_top.sv

  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_alu_top.sv

// ==== verif/tb_alu_vectors.svh ====
`ifndef TB_ALU_VECTORS_SVH
`define TB_ALU_VECTORS_SVH

// Columns are op, a, b, expected result, expected overflow, expected zero
localparam int NUM_DIRECTED = 45;

task automatic load_directed_vectors();
  // Add, subtract, increment and decrement around the sign limits
  add_row(OP_ADD, 16'h0003, 16'h0004, 16'h0007, 1'b0, 1'b0);
  add_row(OP_ADD, 16'h7fff, 16'h0001, 16'h8000, 1'b1, 1'b0);
  add_row(OP_ADD, 16'h8000, 16'h8000, 16'h0000, 1'b1, 1'b1);
  add_row(OP_ADD, 16'hffff, 16'h0001, 16'h0000, 1'b0, 1'b1);
  add_row(OP_SUB, 16'h0005, 16'h0007, 16'hfffe, 1'b0, 1'b0);
  add_row(OP_SUB, 16'h8000, 16'h0001, 16'h7fff, 1'b1, 1'b0);
  add_row(OP_SUB, 16'h7fff, 16'hffff, 16'h8000, 1'b1, 1'b0);
  add_row(OP_INC, 16'h7fff, 16'h0000, 16'h8000, 1'b1, 1'b0);
  add_row(OP_INC, 16'hffff, 16'h0000, 16'h0000, 1'b0, 1'b1);
  add_row(OP_DEC, 16'h8000, 16'h0000, 16'h7fff, 1'b1, 1'b0);
  add_row(OP_DEC, 16'h0000, 16'h0000, 16'hffff, 1'b0, 1'b0);
  // Bitwise operations and their zero flag
  add_row(OP_OR,  16'h00f0, 16'h0f0f, 16'h0fff, 1'b0, 1'b0);
  add_row(OP_OR,  16'h0000, 16'h0000, 16'h0000, 1'b0, 1'b1);
  add_row(OP_AND, 16'ha5c3, 16'h5a3c, 16'h0000, 1'b0, 1'b1);
  add_row(OP_AND, 16'hff0f, 16'h0ff0, 16'h0f00, 1'b0, 1'b0);
  add_row(OP_INV, 16'hffff, 16'h0000, 16'h0000, 1'b0, 1'b1);
  add_row(OP_INV, 16'h1234, 16'h0000, 16'hedcb, 1'b0, 1'b0);
  // Arithmetic shift left with amounts 0, 1, 15, 16 and 40000
  add_row(OP_SLA, 16'h0001, 16'h0000, 16'h0001, 1'b0, 1'b0);
  add_row(OP_SLA, 16'h4000, 16'h0001, 16'h8000, 1'b1, 1'b0);
  add_row(OP_SLA, 16'hc000, 16'h0001, 16'h8000, 1'b0, 1'b0);
  add_row(OP_SLA, 16'hffff, 16'h000f, 16'h8000, 1'b0, 1'b0);
  add_row(OP_SLA, 16'h0001, 16'h000f, 16'h8000, 1'b1, 1'b0);
  add_row(OP_SLA, 16'h0001, 16'h0010, 16'h0000, 1'b1, 1'b1);
  add_row(OP_SLA, 16'h0000, 16'h9c40, 16'h0000, 1'b0, 1'b1);
  // Right shifts and logical left shift never overflow
  add_row(OP_SRA, 16'h1234, 16'h0000, 16'h1234, 1'b0, 1'b0);
  add_row(OP_SRA, 16'h8000, 16'h0001, 16'hc000, 1'b0, 1'b0);
  add_row(OP_SRA, 16'h8000, 16'h000f, 16'hffff, 1'b0, 1'b0);
  add_row(OP_SRA, 16'h8000, 16'h0010, 16'hffff, 1'b0, 1'b0);
  add_row(OP_SRA, 16'h7fff, 16'h9c40, 16'h0000, 1'b0, 1'b1);
  add_row(OP_SLL, 16'h1234, 16'h0000, 16'h1234, 1'b0, 1'b0);
  add_row(OP_SLL, 16'h8001, 16'h0001, 16'h0002, 1'b0, 1'b0);
  add_row(OP_SLL, 16'h0001, 16'h000f, 16'h8000, 1'b0, 1'b0);
  add_row(OP_SLL, 16'hffff, 16'h0010, 16'h0000, 1'b0, 1'b1);
  add_row(OP_SLL, 16'h5555, 16'h9c40, 16'h0000, 1'b0, 1'b1);
  add_row(OP_SRL, 16'habcd, 16'h0000, 16'habcd, 1'b0, 1'b0);
  add_row(OP_SRL, 16'h8000, 16'h0001, 16'h4000, 1'b0, 1'b0);
  add_row(OP_SRL, 16'h8000, 16'h000f, 16'h0001, 1'b0, 1'b0);
  add_row(OP_SRL, 16'h8000, 16'h0010, 16'h0000, 1'b0, 1'b1);
  add_row(OP_SRL, 16'hffff, 16'h9c40, 16'h0000, 1'b0, 1'b1);
  // Signed compare
  add_row(OP_SLE, 16'h1234, 16'h1234, 16'h0001, 1'b0, 1'b0);
  add_row(OP_SLE, 16'h8000, 16'h7fff, 16'h0001, 1'b0, 1'b0);
  add_row(OP_SLE, 16'hffff, 16'h0000, 16'h0001, 1'b0, 1'b0);
  add_row(OP_SLE, 16'h7fff, 16'h8000, 16'h0000, 1'b0, 1'b1);
  // Unused codes
  add_row(alu_op_e'(4'd12), 16'hffff, 16'hffff, 16'h0000, 1'b0, 1'b1);
  add_row(alu_op_e'(4'd15), 16'h7fff, 16'h0001, 16'h0000, 1'b0, 1'b1);
endtask

`endif

// ==== verif/tb_alu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_alu_top;

  import alu_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int STIM_DELAY  = 2;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_RANDOM  = 200;
  localparam logic [15:0] LFSR_SEED = 16'd76;

  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   result;
    logic    overflow;
    logic    zero;
  } vector_t;

  logic          clk;
  logic          arst_n;
  alu_op_e       op;
  alu_operands_t operands;
  word_t         result;
  alu_flags_t    flags;

  vector_t       vectors[$];
  logic [15:0]   lfsr_state;

  `include "tb_alu_vectors.svh"

  alu_top DUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .op       (op),
    .operands (operands),
    .result   (result),
    .flags    (flags)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Reset, every row, one drain cycle and some margin
  initial begin
    #((RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + 10) * CLK_PERIOD);
    $display("Timeout: the vector loop did not finish in time");
    stop_on_failure();
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string what, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] time %0t: %s is %h, expected %h", $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic draw_bits(input int count, output logic [15:0] value);
    value = '0;
    for (int k = 0; k < count; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[14:0], lfsr_state[0]};
    end
  endtask

  task automatic add_row(input alu_op_e code, input word_t a, input word_t b,
                         input word_t res, input logic ovf, input logic zero);
    vector_t row;
    row.op       = code;
    row.a        = a;
    row.b        = b;
    row.result   = res;
    row.overflow = ovf;
    row.zero     = zero;
    vectors.push_back(row);
  endtask

  // Wide signed arithmetic, overflow when the true value leaves 16 bits
  task automatic reference_model(input alu_op_e code, input word_t a, input word_t b,
                                 output word_t res, output logic ovf);
    int sa;
    int sb;
    int wide;
    sa   = $signed(a);
    sb   = $signed(b);
    res  = '0;
    ovf  = 1'b0;
    wide = 0;
    case (code)
      OP_SUB, OP_ADD, OP_DEC, OP_INC: begin
        if (code == OP_SUB) wide = sa - sb;
        else if (code == OP_ADD) wide = sa + sb;
        else if (code == OP_DEC) wide = sa - 1;
        else wide = sa + 1;
        res = wide[15:0];
        ovf = (wide > 32767) || (wide < -32768);
      end
      OP_OR:  res = a | b;
      OP_AND: res = a & b;
      OP_INV: res = ~a;
      OP_SLA: begin
        if (b >= 16) begin
          res = '0;
          ovf = (a != '0);
        end else begin
          wide = sa * (1 << b);
          res  = wide[15:0];
          ovf  = (wide > 32767) || (wide < -32768);
        end
      end
      OP_SRA: begin
        wide = sa >>> ((b >= 16) ? 16 : b);
        res  = wide[15:0];
      end
      OP_SLL: res = (b >= 16) ? 16'h0000 : word_t'(a << b);
      OP_SRL: res = (b >= 16) ? 16'h0000 : word_t'(a >> b);
      OP_SLE: res = (sa <= sb) ? 16'h0001 : 16'h0000;
      default: res = '0;
    endcase
  endtask

  task automatic build_random_vectors();
    logic [15:0] code_bits;
    logic [15:0] a;
    logic [15:0] b;
    word_t       res;
    logic        ovf;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      draw_bits(4, code_bits);
      draw_bits(16, a);
      draw_bits(16, b);
      // Keep shift amounts mostly in range
      if (code_bits[3:0] inside {4'd7, 4'd8, 4'd9, 4'd10}) b = b % 20;
      reference_model(alu_op_e'(code_bits[3:0]), a, b, res, ovf);
      add_row(alu_op_e'(code_bits[3:0]), a, b, res, ovf, (res == '0));
    end
  endtask

  task automatic check_row(input vector_t row, input int index);
    check_equal($sformatf("row %0d result", index), result, row.result);
    check_equal($sformatf("row %0d overflow", index), 16'(flags.overflow), 16'(row.overflow));
    check_equal($sformatf("row %0d zero", index), 16'(flags.zero), 16'(row.zero));
  endtask

  task automatic check_idle_outputs(input string when);
    check_equal({when, " result"}, result, 16'h0000);
    check_equal({when, " overflow"}, 16'(flags.overflow), 16'h0000);
    check_equal({when, " zero"}, 16'(flags.zero), 16'h0000);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    arst_n     = 1'b0;
    op         = OP_ADD;
    operands   = '0;
    lfsr_state = LFSR_SEED;

    load_directed_vectors();
    if (vectors.size() != NUM_DIRECTED) begin
      $display("The directed table holds %0d rows instead of %0d",
               vectors.size(), NUM_DIRECTED);
      stop_on_failure();
    end
    build_random_vectors();

    repeat (2) @(posedge clk);
    #STIM_DELAY;
    check_idle_outputs("in reset");
    repeat (RESET_CYCLES - 2) @(posedge clk);
    #STIM_DELAY;
    arst_n = 1'b1;
    #1;
    check_idle_outputs("after release");

    // Each row is checked on the cycle after it is applied
    for (int i = 0; i < vectors.size(); i++) begin
      @(posedge clk);
      #STIM_DELAY;
      if (i > 0) check_row(vectors[i - 1], i - 1);
      op       = vectors[i].op;
      operands = {vectors[i].a, vectors[i].b};
    end
    @(posedge clk);
    #STIM_DELAY;
    check_row(vectors[vectors.size() - 1], vectors.size() - 1);

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/alu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  alu_pkg::alu_op_e       op,
  input  alu_pkg::alu_operands_t operands,
  output alu_pkg::word_t         result,
  output alu_pkg::alu_flags_t    flags
);

  import alu_pkg::*;

  arith_out_t arith;
  shift_out_t shifts;

  //////////////////////////////////////////////////////////////////////
  // Parallel units
  //////////////////////////////////////////////////////////////////////

  // Both units see only the operands and compute every result
  alu_arith u_arith (
    .operands (operands),
    .arith    (arith)
  );

  alu_shift u_shift (
    .operands (operands),
    .shifts   (shifts)
  );

  //////////////////////////////////////////////////////////////////////
  // Select and register
  //////////////////////////////////////////////////////////////////////

  // Opcode decode lives only here, one cycle of latency
  alu_result_stage u_result_stage (
    .clk      (clk),
    .arst_n   (arst_n),
    .op       (op),
    .operands (operands),
    .arith    (arith),
    .shifts   (shifts),
    .result   (result),
    .flags    (flags)
  );

endmodule

`default_nettype wire

// ==== logic/alu_result_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_result_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  alu_pkg::alu_op_e       op,
  input  alu_pkg::alu_operands_t operands,
  input  alu_pkg::arith_out_t    arith,
  input  alu_pkg::shift_out_t    shifts,
  output alu_pkg::word_t         result,
  output alu_pkg::alu_flags_t    flags
);

  import alu_pkg::*;

  word_t bit_or;
  word_t bit_and;
  word_t bit_inv;
  word_t next_result;
  logic  next_ovf;
  logic  next_zero;

  //////////////////////////////////////////////////////////////////////
  // Bitwise operations
  //////////////////////////////////////////////////////////////////////

  assign bit_or  = operands.a | operands.b;
  assign bit_and = operands.a & operands.b;
  assign bit_inv = ~operands.a;

  //////////////////////////////////////////////////////////////////////
  // Opcode select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    next_result = '0;
    next_ovf    = 1'b0;
    case (op)
      OP_SUB: begin
        next_result = arith.diff;
        next_ovf    = arith.ovf_sub;
      end
      OP_ADD: begin
        next_result = arith.sum;
        next_ovf    = arith.ovf_add;
      end
      OP_OR:  next_result = bit_or;
      OP_AND: next_result = bit_and;
      OP_DEC: begin
        next_result = arith.dec;
        next_ovf    = arith.ovf_dec;
      end
      OP_INC: begin
        next_result = arith.inc;
        next_ovf    = arith.ovf_inc;
      end
      OP_INV: next_result = bit_inv;
      OP_SLA: begin
        next_result = shifts.sla;
        next_ovf    = shifts.ovf_sla;
      end
      OP_SRA: next_result = shifts.sra;
      OP_SLL: next_result = shifts.sll;
      OP_SRL: next_result = shifts.srl;
      // Compare result lands in bit 0 only
      OP_SLE: next_result = word_t'(arith.le);
      // Unused codes keep the zero result
      default: begin
        next_result = '0;
        next_ovf    = 1'b0;
      end
    endcase
  end

  // Zero detect on the selected word, ahead of the register
  assign next_zero = ~|next_result;

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
      flags  <= '0;
    end else begin
      result         <= next_result;
      flags.overflow <= next_ovf;
      flags.zero     <= next_zero;
    end
  end

  // Only add, subtract, increment, decrement and arithmetic left shift
  // may raise overflow on the following cycle
  a_ovf_only_arith : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(op inside {OP_SUB, OP_ADD, OP_DEC, OP_INC, OP_SLA}) |=> !flags.overflow
  );

endmodule

`default_nettype wire

// ==== logic/alu_shift.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_shift (
  input  alu_pkg::alu_operands_t operands,
  output alu_pkg::shift_out_t    shifts
);

  import alu_pkg::*;

  word_t a;
  word_t amount;
  word_t shifted_left;
  word_t shifted_right_arith;
  word_t shifted_right_logic;
  word_t shifted_back;
  logic  sla_ovf;

  assign a      = operands.a;
  // b is always an unsigned shift amount
  assign amount = operands.b;

  //////////////////////////////////////////////////////////////////////
  // Shifters
  //////////////////////////////////////////////////////////////////////

  // Arithmetic and logical left shifts produce the same bits
  // Amounts of 16 or more clear the word
  assign shifted_left = a << amount;

  // Sign fill, all copies of the sign for large amounts
  assign shifted_right_arith = word_t'($signed(a) >>> amount);

  assign shifted_right_logic = a >> amount;

  //////////////////////////////////////////////////////////////////////
  // Arithmetic left shift overflow
  //////////////////////////////////////////////////////////////////////

  // Shift the result back with sign fill.
  // The top bits then hold copies of the result sign, so any bit
  // lost on the way out shows up as a mismatch against a.
  // A nonzero a with a large amount comes back as 0 and flags too
  assign shifted_back = word_t'($signed(shifted_left) >>> amount);
  assign sla_ovf      = (shifted_back != a);

  always_comb begin
    shifts.sla     = shifted_left;
    shifts.sra     = shifted_right_arith;
    shifts.sll     = shifted_left;
    shifts.srl     = shifted_right_logic;
    shifts.ovf_sla = sla_ovf;
  end

  // A zero shift loses nothing
  a_no_sla_ovf_on_zero : assert property (
    @(operands) (operands.b == '0) |-> !shifts.ovf_sla
  );

endmodule

`default_nettype wire

// ==== logic/alu_arith.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_arith (
  input  alu_pkg::alu_operands_t operands,
  output alu_pkg::arith_out_t    arith
);

  import alu_pkg::*;

  localparam int unsigned MSB = WORD_WIDTH - 1;

  // Largest positive two's-complement word
  localparam word_t MAX_POS = {1'b0, {MSB{1'b1}}};

  word_t a;
  word_t b;
  word_t diff;
  word_t sum;
  word_t dec;
  word_t inc;
  logic  signs_differ;
  logic  diff_is_zero;
  logic  le;

  assign a = operands.a;
  assign b = operands.b;

  //////////////////////////////////////////////////////////////////////
  // Adders
  //////////////////////////////////////////////////////////////////////

  // All four wrap at the word width
  assign diff = a - b;
  assign sum  = a + b;
  assign dec  = a - 1'b1;
  assign inc  = a + 1'b1;

  assign signs_differ = a[MSB] ^ b[MSB];
  assign diff_is_zero = ~|diff;

  // Signed a <= b
  // With differing signs a negative a always wins and the
  // subtraction may overflow, so the difference is not trusted.
  // With equal signs the difference is exact
  assign le = signs_differ ? a[MSB] : (diff[MSB] | diff_is_zero);

  //////////////////////////////////////////////////////////////////////
  // Overflow from sign bits
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    arith.diff = diff;
    arith.sum  = sum;
    arith.dec  = dec;
    arith.inc  = inc;

    // Subtract: operand signs differ and result leaves a's sign
    arith.ovf_sub = signs_differ & (diff[MSB] ^ a[MSB]);

    // Add: operands agree in sign and the result does not
    arith.ovf_add = ~signs_differ & (sum[MSB] ^ a[MSB]);

    // Negative to positive on decrement
    arith.ovf_dec = a[MSB] & ~dec[MSB];

    // Positive to negative on increment
    arith.ovf_inc = ~a[MSB] & inc[MSB];

    arith.le = le;
  end

  // Only the largest positive word can overflow on increment
  a_inc_ovf_only_max : assert property (
    @(operands) arith.ovf_inc |-> (operands.a == MAX_POS)
  );

endmodule

`default_nettype wire

// ==== logic/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  // Datapath width, fixed for this unit
  localparam int unsigned WORD_WIDTH = 16;

  typedef logic [WORD_WIDTH-1:0] word_t;

  // Codes 12 to 15 are unused and give a zero result
  typedef enum logic [3:0] {
    OP_SUB = 4'd0,
    OP_ADD = 4'd1,
    OP_OR  = 4'd2,
    OP_AND = 4'd3,
    OP_DEC = 4'd4,
    OP_INC = 4'd5,
    OP_INV = 4'd6,
    OP_SLA = 4'd7,
    OP_SRA = 4'd8,
    OP_SLL = 4'd9,
    OP_SRL = 4'd10,
    OP_SLE = 4'd11
  } alu_op_e;

  typedef struct packed {
    word_t a;
    word_t b;
  } alu_operands_t;

  typedef struct packed {
    logic overflow;
    logic zero;
  } alu_flags_t;

  //////////////////////////////////////////////////////////////////////
  // Results of the parallel units
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    word_t diff;
    word_t sum;
    word_t dec;
    word_t inc;
    logic  ovf_sub;
    logic  ovf_add;
    logic  ovf_dec;
    logic  ovf_inc;
    logic  le;
  } arith_out_t;

  typedef struct packed {
    word_t sla;
    word_t sra;
    word_t sll;
    word_t srl;
    logic  ovf_sla;
  } shift_out_t;

endpackage

`default_nettype wire
